// File: cpu_pkg.sv
package cpu_pkg;

   // Instruction class in bits 31..27
   typedef enum logic [4:0] {
      OP_NOP   = 5'd0,
      OP_LDI   = 5'd1,
      OP_ALU   = 5'd2,
      OP_LOAD  = 5'd3,
      OP_STORE = 5'd4,
      OP_JNZ   = 5'd5,
      OP_HALT  = 5'd6
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLL = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SLT = 4'd7
   } alu_op_e;

   // Register format
   typedef struct packed {
      opcode_e    opcode;
      logic [4:0] rd;
      logic [4:0] rs0;
      logic [4:0] rs1;
      alu_op_e    alu_op;
      logic [7:0] spare;
   } instr_r_t;

   // Immediate format, imm is sign-extended by LDI
   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [21:0] imm;
   } instr_i_t;

   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   // Classes that write rd at write-back
   function automatic logic writes_rd(opcode_e op);
      return op inside {OP_LDI, OP_ALU, OP_LOAD};
   endfunction

   // Classes that read rs0 or rs1
   function automatic logic uses_rs0(opcode_e op);
      return op inside {OP_ALU, OP_LOAD, OP_STORE, OP_JNZ};
   endfunction

   function automatic logic uses_rs1(opcode_e op);
      return op inside {OP_ALU, OP_STORE, OP_JNZ};
   endfunction

endpackage

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
   parameter int imem_aw = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                imem_we,
   input  logic [imem_aw-1:0]  imem_addr,
   input  logic [31:0]         imem_wdata,
   input  logic                stall,
   input  logic                freeze,
   input  logic                flush,
   input  logic [31:0]         jump_target,
   output cpu_pkg::instr_u     issue_instr
);

   logic [31:0] imem [2**imem_aw];
   logic [31:0] pc;
   logic        advance;

   assign advance = run && !stall && !freeze;

   // Program port, only while the core is idle
   always_ff @(posedge clk) begin
      if (imem_we && !run) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // PC runs one word ahead of the issue register
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc          <= '0;
         issue_instr <= '0;
      end else if (flush) begin
         // Squash the word fetched behind the jump
         pc          <= jump_target;
         issue_instr <= '0;
      end else if (advance) begin
         pc          <= pc + 32'd1;
         issue_instr <= imem[pc[imem_aw-1:0]];
      end
   end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::instr_u  issue_instr,
   input  logic             stall,
   input  logic             freeze,
   input  logic             flush,
   input  logic [4:0]       wb_rd,
   input  logic [31:0]      wb_wdata,
   input  logic             wb_wen,
   output cpu_pkg::instr_u  ex_instr,
   output logic [31:0]      ex_op0,
   output logic [31:0]      ex_op1,
   output logic [31:0]      ex_imm,
   output logic             ex_valid,
   output logic [4:0]       ex_rd,
   output logic             ex_writes
);
   import cpu_pkg::*;

   logic [31:0] regs [32];
   logic [4:0]  rs0;
   logic [4:0]  rs1;
   logic [31:0] rdata0;
   logic [31:0] rdata1;
   logic [31:0] imm_ext;
   logic        bubble;

   // Same word read as both formats
   assign rs0     = issue_instr.r.rs0;
   assign rs1     = issue_instr.r.rs1;
   assign imm_ext = {{10{issue_instr.i.imm[21]}}, issue_instr.i.imm};

   always_ff @(posedge clk) begin
      if (wb_wen) begin
         regs[wb_rd] <= wb_wdata;
      end
   end

   // r0 reads zero, a write in this cycle is passed straight through
   assign rdata0 = (rs0 == 5'd0) ? 32'd0 :
                   (wb_wen && wb_rd == rs0) ? wb_wdata : regs[rs0];
   assign rdata1 = (rs1 == 5'd0) ? 32'd0 :
                   (wb_wen && wb_rd == rs1) ? wb_wdata : regs[rs1];

   assign bubble = stall || flush;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ex_instr <= '0;
         ex_valid <= 1'b0;
      end else if (!freeze) begin
         if (bubble) begin
            ex_instr <= '0;
            ex_valid <= 1'b0;
         end else begin
            ex_instr <= issue_instr;
            ex_valid <= (issue_instr.r.opcode != OP_NOP);
         end
      end
   end

   // Operand payload
   always_ff @(posedge clk) begin
      if (!freeze) begin
         ex_op0 <= rdata0;
         ex_op1 <= rdata1;
         ex_imm <= imm_ext;
      end
   end

   assign ex_rd     = ex_instr.r.rd;
   assign ex_writes = ex_valid && writes_rd(ex_instr.r.opcode);

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
   input  logic             clk,
   input  logic             rst,
   input  logic             freeze,
   input  cpu_pkg::instr_u  ex_instr,
   input  logic [31:0]      ex_op0,
   input  logic [31:0]      ex_op1,
   input  logic [31:0]      ex_imm,
   input  logic             ex_valid,
   output cpu_pkg::instr_u  mem_instr,
   output logic [31:0]      mem_result,
   output logic [31:0]      mem_store_data,
   output logic             mem_valid,
   output logic [4:0]       mem_rd,
   output logic             mem_writes,
   output logic             jump_taken,
   output logic [31:0]      jump_target
);
   import cpu_pkg::*;

   logic [31:0] alu_out;
   logic [31:0] result;

   always_comb begin
      case (ex_instr.r.alu_op)
         ALU_ADD: alu_out = ex_op0 + ex_op1;
         ALU_SUB: alu_out = ex_op0 - ex_op1;
         ALU_AND: alu_out = ex_op0 & ex_op1;
         ALU_OR:  alu_out = ex_op0 | ex_op1;
         ALU_XOR: alu_out = ex_op0 ^ ex_op1;
         ALU_SLL: alu_out = ex_op0 << ex_op1[4:0];
         ALU_SRL: alu_out = ex_op0 >> ex_op1[4:0];
         ALU_SLT: alu_out = {31'd0, $signed(ex_op0) < $signed(ex_op1)};
         default: alu_out = 32'd0;
      endcase
   end

   // LOAD addresses by rs0, STORE by rs1
   always_comb begin
      case (ex_instr.r.opcode)
         OP_LDI:   result = ex_imm;
         OP_ALU:   result = alu_out;
         OP_LOAD:  result = ex_op0;
         OP_STORE: result = ex_op1;
         default:  result = 32'd0;
      endcase
   end

   assign jump_taken  = ex_valid && ex_instr.r.opcode == OP_JNZ && ex_op0 != 32'd0;
   assign jump_target = ex_op1;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem_instr <= '0;
         mem_valid <= 1'b0;
      end else if (!freeze) begin
         mem_instr <= ex_instr;
         mem_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!freeze) begin
         mem_result     <= result;
         mem_store_data <= ex_op0;
      end
   end

   assign mem_rd     = mem_instr.r.rd;
   assign mem_writes = mem_valid && writes_rd(mem_instr.r.opcode);

endmodule

// File: memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::instr_u  mem_instr,
   input  logic [31:0]      mem_result,
   input  logic [31:0]      mem_store_data,
   input  logic             mem_valid,
   input  logic [31:0]      wb_dat_i,
   input  logic             wb_ack,
   output logic             wb_cyc,
   output logic             wb_stb,
   output logic             wb_we,
   output logic [31:0]      wb_adr,
   output logic [31:0]      wb_dat_o,
   output logic             mem_busy,
   output logic [4:0]       wb_rd,
   output logic [31:0]      wb_wdata,
   output logic             wb_wen,
   output logic             wbk_valid
);
   import cpu_pkg::*;

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_XFER = 1'b1;

   logic state;
   logic is_load;
   logic is_store;
   logic mem_req;

   assign is_load  = mem_valid && mem_instr.r.opcode == OP_LOAD;
   assign is_store = mem_valid && mem_instr.r.opcode == OP_STORE;
   assign mem_req  = is_load || is_store;

   // Cycle opens the edge after the access reaches this stage
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (mem_req) state <= ST_XFER;
            ST_XFER: if (wb_ack)  state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // The pipeline is frozen during the cycle, so address and data hold
   assign wb_cyc   = (state == ST_XFER);
   assign wb_stb   = (state == ST_XFER);
   assign wb_we    = (state == ST_XFER) && is_store;
   assign wb_adr   = mem_result;
   assign wb_dat_o = mem_store_data;

   // Busy from the pending cycle until ack
   assign mem_busy = (state == ST_IDLE) ? mem_req : !wb_ack;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wbk_valid <= 1'b0;
         wb_wen    <= 1'b0;
      end else if (!mem_busy) begin
         wbk_valid <= mem_valid;
         wb_wen    <= mem_valid && writes_rd(mem_instr.r.opcode);
      end
   end

   // Load data is taken in the ack cycle
   always_ff @(posedge clk) begin
      if (!mem_busy) begin
         wb_rd    <= mem_instr.r.rd;
         wb_wdata <= is_load ? wb_dat_i : mem_result;
      end
   end

endmodule

// File: pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::instr_u  issue_instr,
   input  logic             ex_valid,
   input  logic [4:0]       ex_rd,
   input  logic             ex_writes,
   input  logic             mem_valid,
   input  logic [4:0]       mem_rd,
   input  logic             mem_writes,
   input  logic             wbk_valid,
   input  logic             jump_taken,
   input  logic             mem_busy,
   output logic             stall,
   output logic             freeze,
   output logic             flush,
   output logic             halted
);
   import cpu_pkg::*;

   logic [4:0] rs0;
   logic [4:0] rs1;
   logic [4:0] ex_dst;
   logic [4:0] mem_dst;
   logic       hit_rs0;
   logic       hit_rs1;
   logic       is_halt;
   logic       drained;

   assign rs0 = issue_instr.r.rs0;
   assign rs1 = issue_instr.r.rs1;

   // A destination of r0 counts as no writer
   assign ex_dst  = (ex_valid && ex_writes) ? ex_rd : 5'd0;
   assign mem_dst = (mem_valid && mem_writes) ? mem_rd : 5'd0;

   assign hit_rs0 = uses_rs0(issue_instr.r.opcode) && rs0 != 5'd0 &&
                    (rs0 == ex_dst || rs0 == mem_dst);
   assign hit_rs1 = uses_rs1(issue_instr.r.opcode) && rs1 != 5'd0 &&
                    (rs1 == ex_dst || rs1 == mem_dst);

   // HALT stays parked in the issue register
   assign is_halt = (issue_instr.r.opcode == OP_HALT);

   assign stall  = hit_rs0 || hit_rs1 || is_halt;
   assign freeze = mem_busy;
   assign flush  = jump_taken && !freeze;

   assign drained = !ex_valid && !mem_valid && !wbk_valid && !mem_busy;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         halted <= 1'b0;
      end else if (is_halt && drained) begin
         halted <= 1'b1;
      end
   end

endmodule

// File: cpu_pipelined.sv
`timescale 1ns/100ps

module cpu_pipelined #(
   parameter int imem_aw = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                imem_we,
   input  logic [imem_aw-1:0]  imem_addr,
   input  logic [31:0]         imem_wdata,
   output logic                halted,
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output logic [31:0]         wb_adr,
   output logic [31:0]         wb_dat_o,
   input  logic [31:0]         wb_dat_i,
   input  logic                wb_ack
);
   import cpu_pkg::*;

   instr_u      issue_instr;
   instr_u      ex_instr;
   instr_u      mem_instr;
   logic [31:0] ex_op0;
   logic [31:0] ex_op1;
   logic [31:0] ex_imm;
   logic        ex_valid;
   logic [4:0]  ex_rd;
   logic        ex_writes;
   logic [31:0] mem_result;
   logic [31:0] mem_store_data;
   logic        mem_valid;
   logic [4:0]  mem_rd;
   logic        mem_writes;
   logic        jump_taken;
   logic [31:0] jump_target;
   logic        mem_busy;
   logic        wbk_valid;
   logic [4:0]  wb_rd;
   logic [31:0] wb_wdata;
   logic        wb_wen;
   logic        stall;
   logic        freeze;
   logic        flush;

   fetch_stage #(
      .imem_aw(imem_aw)
   ) i_fetch (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .imem_we     (imem_we),
      .imem_addr   (imem_addr),
      .imem_wdata  (imem_wdata),
      .stall       (stall),
      .freeze      (freeze),
      .flush       (flush),
      .jump_target (jump_target),
      .issue_instr (issue_instr)
   );

   decode_stage i_decode (
      .clk         (clk),
      .rst         (rst),
      .issue_instr (issue_instr),
      .stall       (stall),
      .freeze      (freeze),
      .flush       (flush),
      .wb_rd       (wb_rd),
      .wb_wdata    (wb_wdata),
      .wb_wen      (wb_wen),
      .ex_instr    (ex_instr),
      .ex_op0      (ex_op0),
      .ex_op1      (ex_op1),
      .ex_imm      (ex_imm),
      .ex_valid    (ex_valid),
      .ex_rd       (ex_rd),
      .ex_writes   (ex_writes)
   );

   execute_stage i_execute (
      .clk            (clk),
      .rst            (rst),
      .freeze         (freeze),
      .ex_instr       (ex_instr),
      .ex_op0         (ex_op0),
      .ex_op1         (ex_op1),
      .ex_imm         (ex_imm),
      .ex_valid       (ex_valid),
      .mem_instr      (mem_instr),
      .mem_result     (mem_result),
      .mem_store_data (mem_store_data),
      .mem_valid      (mem_valid),
      .mem_rd         (mem_rd),
      .mem_writes     (mem_writes),
      .jump_taken     (jump_taken),
      .jump_target    (jump_target)
   );

   memory_stage i_memory (
      .clk            (clk),
      .rst            (rst),
      .mem_instr      (mem_instr),
      .mem_result     (mem_result),
      .mem_store_data (mem_store_data),
      .mem_valid      (mem_valid),
      .wb_dat_i       (wb_dat_i),
      .wb_ack         (wb_ack),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_o       (wb_dat_o),
      .mem_busy       (mem_busy),
      .wb_rd          (wb_rd),
      .wb_wdata       (wb_wdata),
      .wb_wen         (wb_wen),
      .wbk_valid      (wbk_valid)
   );

   pipeline_control i_control (
      .clk         (clk),
      .rst         (rst),
      .issue_instr (issue_instr),
      .ex_valid    (ex_valid),
      .ex_rd       (ex_rd),
      .ex_writes   (ex_writes),
      .mem_valid   (mem_valid),
      .mem_rd      (mem_rd),
      .mem_writes  (mem_writes),
      .wbk_valid   (wbk_valid),
      .jump_taken  (jump_taken),
      .mem_busy    (mem_busy),
      .stall       (stall),
      .freeze      (freeze),
      .flush       (flush),
      .halted      (halted)
   );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset low over three rising edges, released on a falling edge
   initial begin
      rst = 1'b1;
      #1 rst = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst <= 1'b1;
   end

endmodule

// File: cpu_assert.sv
`timescale 1ns/100ps

module cpu_assert (
   input logic        clk,
   input logic        rst,
   input logic        wb_cyc,
   input logic        wb_stb,
   input logic        wb_we,
   input logic [31:0] wb_adr,
   input logic [31:0] wb_dat_o,
   input logic        wb_ack
);

   // Failed assertion count
   int fail_count = 0;

   // Strobe only inside an open cycle
   stb_in_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
      else begin
         $error("wb_stb high without wb_cyc");
         fail_count++;
      end

   // Request held until the slave acknowledges
   req_stable: assert property (@(posedge clk) disable iff (!rst)
      wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o))
      else begin
         $error("Wishbone request changed before ack");
         fail_count++;
      end

   no_cyc_in_reset: assert property (@(posedge clk) !rst |-> !wb_cyc)
      else begin
         $error("wb_cyc high during reset");
         fail_count++;
      end

endmodule

bind memory_stage cpu_assert i_wb_assert (
   .clk      (clk),
   .rst      (rst),
   .wb_cyc   (wb_cyc),
   .wb_stb   (wb_stb),
   .wb_we    (wb_we),
   .wb_adr   (wb_adr),
   .wb_dat_o (wb_dat_o),
   .wb_ack   (wb_ack)
);

// File: tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
   import cpu_pkg::*;

   localparam int imem_aw     = 8;
   localparam int dmem_words  = 64;
   localparam int run_timeout = 3000;

   logic               clk;
   logic               gen_rst;
   logic               soft_rst;
   logic               dut_rst;
   logic               run;
   logic               imem_we;
   logic [imem_aw-1:0] imem_addr;
   logic [31:0]        imem_wdata;
   logic               halted;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   logic [31:0]        wb_adr;
   logic [31:0]        wb_dat_o;
   logic [31:0]        wb_dat_i;
   logic               wb_ack;

   logic [31:0] prog [2**imem_aw];
   int          plen;
   logic [31:0] dmem [dmem_words];
   logic [31:0] ref_mem [dmem_words];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   logic [31:0] obs_adr [$];
   logic [31:0] obs_dat [$];
   logic [31:0] got_adr;
   logic [31:0] got_dat;
   logic [31:0] lcg_state = 32'h4cf4_1aab;
   int          ack_wait = 1;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          assert_fails = 0;

   // Power-on reset from the generator, per-test reset from the stimulus
   assign dut_rst = gen_rst && soft_rst;

   tb_clock_gen i_clock_gen (
      .clk (clk),
      .rst (gen_rst)
   );

   cpu_pipelined #(
      .imem_aw(imem_aw)
   ) i_dut (
      .clk        (clk),
      .rst        (dut_rst),
      .run        (run),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .halted     (halted),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_dat_i   (wb_dat_i),
      .wb_ack     (wb_ack)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int pick_ack_delay();
      logic [31:0] v;
      v = next_rand();
      return int'(v[17:16]);
   endfunction

   function automatic logic [31:0] fill_word(input int a);
      return (32'(a) * 32'h9e37_79b9) ^ 32'h0f0f_0000;
   endfunction

   function automatic logic [31:0] ldi_instr(input logic [4:0] rd, input logic [21:0] imm);
      return {OP_LDI, rd, imm};
   endfunction

   function automatic logic [31:0] alu_instr(input alu_op_e op, input logic [4:0] rd,
                                             input logic [4:0] rs0, input logic [4:0] rs1);
      return {OP_ALU, rd, rs0, rs1, op, 8'd0};
   endfunction

   function automatic logic [31:0] load_instr(input logic [4:0] rd, input logic [4:0] adr);
      return {OP_LOAD, rd, adr, 5'd0, 12'd0};
   endfunction

   function automatic logic [31:0] store_instr(input logic [4:0] src, input logic [4:0] adr);
      return {OP_STORE, 5'd0, src, adr, 12'd0};
   endfunction

   function automatic logic [31:0] jnz_instr(input logic [4:0] cond, input logic [4:0] target);
      return {OP_JNZ, 5'd0, cond, target, 12'd0};
   endfunction

   function automatic logic [31:0] halt_instr();
      return {OP_HALT, 27'd0};
   endfunction

   function automatic void emit(input logic [31:0] w);
      prog[plen] = w;
      plen++;
   endfunction

   function automatic logic [31:0] alu_result(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_SLL: return a << b[4:0];
         ALU_SRL: return a >> b[4:0];
         ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: return 32'd0;
      endcase
   endfunction

   // Instruction-level model: expected stores in order and final data memory
   function automatic void reference_run();
      logic [31:0] regs [32];
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  rd;
      int          pc;
      int          steps;
      for (int k = 0; k < 32; k++) begin
         regs[k] = '0;
      end
      for (int k = 0; k < dmem_words; k++) begin
         ref_mem[k] = fill_word(k);
      end
      pc = 0;
      steps = 0;
      while (steps < 4000) begin
         w = prog[pc];
         rd = w[26:22];
         a = regs[w[21:17]];
         b = regs[w[16:12]];
         pc = (pc + 1) % (2**imem_aw);
         steps++;
         if (w[31:27] == OP_HALT) begin
            break;
         end
         case (w[31:27])
            OP_LDI:  regs[rd] = {{10{w[21]}}, w[21:0]};
            OP_ALU:  regs[rd] = alu_result(w[11:8], a, b);
            OP_LOAD: regs[rd] = ref_mem[a[5:0]];
            OP_STORE: begin
               ref_mem[b[5:0]] = a;
               exp_adr.push_back(b);
               exp_dat.push_back(a);
            end
            OP_JNZ:  if (a != 32'd0) pc = int'(b[imem_aw-1:0]);
            default: ;
         endcase
         regs[0] = '0;
      end
   endfunction

   function automatic void expect_bit(input string name, input logic got, input logic want);
      assert (got === want) else begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, want);
         errors++;
      end
   endfunction

   function automatic void compare_word(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
      assert (got === want) else begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
         errors++;
      end
   endfunction

   // Wishbone slave with a random ack delay of 0 to 3 cycles
   always @(negedge clk) begin
      if (wb_ack) begin
         wb_ack <= 1'b0;
      end else if (wb_cyc === 1'b1 && wb_stb === 1'b1) begin
         if (ack_wait == 0) begin
            wb_ack   <= 1'b1;
            wb_dat_i <= dmem[wb_adr[5:0]];
            if (wb_we) begin
               dmem[wb_adr[5:0]] = wb_dat_o;
               obs_adr.push_back(wb_adr);
               obs_dat.push_back(wb_dat_o);
            end
            ack_wait = pick_ack_delay();
         end else begin
            ack_wait--;
         end
      end
   end

   // Each observed store against the next expected one
   always @(posedge clk) begin
      while (obs_adr.size() > 0) begin
         got_adr = obs_adr.pop_front();
         got_dat = obs_dat.pop_front();
         assert (exp_adr.size() > 0) else begin
            $display("Store of %h to %h at %0t was not expected", got_dat, got_adr, $time);
            errors++;
         end
         if (exp_adr.size() > 0) begin
            compare_word("wb_adr", got_adr, exp_adr.pop_front());
            compare_word("wb_dat_o", got_dat, exp_dat.pop_front());
         end
      end
   end

   task automatic report_test(input string name, input int errs_at_start);
      int new_fails;
      new_fails = i_dut.i_memory.i_wb_assert.fail_count - assert_fails;
      if (new_fails > 0) begin
         $display("%0d Wishbone protocol assertion failures in test %s", new_fails, name);
         errors += new_fails;
         assert_fails += new_fails;
      end
      tests_run++;
      if (errors == errs_at_start) begin
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: FAILED with %0d errors", name, errors - errs_at_start);
      end
   endtask

   task automatic check_reset_state();
      int n;
      int errs_at_start;
      errs_at_start = errors;
      n = 0;
      @(negedge clk);
      while (gen_rst !== 1'b1 && n < 20) begin
         expect_bit("wb_cyc", wb_cyc, 1'b0);
         expect_bit("wb_stb", wb_stb, 1'b0);
         expect_bit("wb_we", wb_we, 1'b0);
         expect_bit("halted", halted, 1'b0);
         @(negedge clk);
         n++;
      end
      assert (gen_rst === 1'b1) else begin
         $display("Timeout: reset was not released within 20 cycles");
         errors++;
      end
      // Idle with run low
      repeat (4) begin
         @(negedge clk);
         expect_bit("wb_cyc", wb_cyc, 1'b0);
         expect_bit("wb_stb", wb_stb, 1'b0);
         expect_bit("wb_we", wb_we, 1'b0);
         expect_bit("halted", halted, 1'b0);
      end
      report_test("reset_state", errs_at_start);
   endtask

   task automatic run_test(input string name);
      int n;
      int errs_at_start;
      errs_at_start = errors;
      exp_adr.delete();
      exp_dat.delete();
      for (int a = 0; a < dmem_words; a++) begin
         dmem[a] = fill_word(a);
      end
      reference_run();
      @(negedge clk);
      run      <= 1'b0;
      soft_rst <= 1'b0;
      for (int k = 0; k < plen; k++) begin
         imem_we    <= 1'b1;
         imem_addr  <= k[imem_aw-1:0];
         imem_wdata <= prog[k];
         @(negedge clk);
      end
      imem_we  <= 1'b0;
      soft_rst <= 1'b1;
      @(negedge clk);
      run <= 1'b1;
      n = 0;
      while (halted !== 1'b1 && n < run_timeout) begin
         @(negedge clk);
         n++;
      end
      if (halted !== 1'b1) begin
         $display("Timeout: halted did not rise within %0d cycles in test %s", run_timeout, name);
         errors++;
      end else begin
         // Bus stays quiet and halted stays high
         repeat (8) begin
            @(negedge clk);
            expect_bit("wb_cyc", wb_cyc, 1'b0);
            expect_bit("halted", halted, 1'b1);
         end
      end
      assert (exp_adr.size() == 0) else begin
         $display("%0d expected stores never appeared on the bus", exp_adr.size());
         errors++;
      end
      for (int a = 0; a < dmem_words; a++) begin
         compare_word($sformatf("dmem[%0d]", a), dmem[a], ref_mem[a]);
      end
      run <= 1'b0;
      report_test(name, errs_at_start);
   endtask

   task automatic build_alu_program();
      logic [31:0] v;
      plen = 0;
      for (int k = 0; k < 8; k++) begin
         v = next_rand();
         emit(ldi_instr(5'd1, v[21:0]));
         v = next_rand();
         emit(ldi_instr(5'd2, v[31:10]));
         emit(alu_instr(alu_op_e'(k), 5'd3, 5'd1, 5'd2));
         emit(ldi_instr(5'd4, 22'(k)));
         emit(store_instr(5'd3, 5'd4));
      end
      emit(halt_instr());
   endtask

   // Back-to-back consumers of ALU and load results
   task automatic build_hazard_program();
      logic [31:0] v;
      plen = 0;
      v = next_rand();
      emit(ldi_instr(5'd1, v[21:0]));
      emit(alu_instr(ALU_ADD, 5'd2, 5'd1, 5'd1));
      emit(alu_instr(ALU_XOR, 5'd3, 5'd2, 5'd1));
      emit(alu_instr(ALU_SUB, 5'd1, 5'd3, 5'd2));
      emit(ldi_instr(5'd5, 22'd10));
      emit(store_instr(5'd1, 5'd5));
      emit(load_instr(5'd6, 5'd5));
      emit(alu_instr(ALU_ADD, 5'd7, 5'd6, 5'd6));
      emit(ldi_instr(5'd8, 22'd11));
      emit(store_instr(5'd7, 5'd8));
      emit(ldi_instr(5'd10, 22'd20));
      emit(load_instr(5'd11, 5'd10));
      emit(load_instr(5'd12, 5'd11));
      emit(alu_instr(ALU_OR, 5'd13, 5'd12, 5'd11));
      emit(ldi_instr(5'd14, 22'd12));
      emit(store_instr(5'd13, 5'd14));
      emit(halt_instr());
   endtask

   task automatic build_memory_program();
      logic [31:0] v;
      plen = 0;
      for (int k = 0; k < 6; k++) begin
         v = next_rand();
         emit(ldi_instr(5'd1, {16'd0, v[5:0]}));
         emit(ldi_instr(5'd2, v[27:6]));
         emit(store_instr(5'd2, 5'd1));
      end
      // Copy words into the upper half
      for (int k = 0; k < 6; k++) begin
         v = next_rand();
         emit(ldi_instr(5'd3, {16'd0, v[5:0]}));
         emit(load_instr(5'd4, 5'd3));
         emit(ldi_instr(5'd5, {16'd0, 1'b1, v[12:8]}));
         emit(store_instr(5'd4, 5'd5));
      end
      emit(halt_instr());
   endtask

   task automatic build_jump_program();
      plen = 0;
      emit(ldi_instr(5'd1, 22'd4));
      emit(ldi_instr(5'd2, 22'd1));
      emit(ldi_instr(5'd3, 22'd4));
      emit(ldi_instr(5'd4, 22'd40));
      // Loop body at word 4
      emit(store_instr(5'd1, 5'd4));
      emit(alu_instr(ALU_ADD, 5'd4, 5'd4, 5'd2));
      emit(alu_instr(ALU_SUB, 5'd1, 5'd1, 5'd2));
      emit(jnz_instr(5'd1, 5'd3));
      // Squashed on every taken jump above
      emit(store_instr(5'd2, 5'd4));
      emit(store_instr(5'd3, 5'd4));
      emit(ldi_instr(5'd5, 22'd14));
      emit(jnz_instr(5'd0, 5'd5));
      emit(jnz_instr(5'd2, 5'd5));
      emit(store_instr(5'd5, 5'd5));
      emit(halt_instr());
   endtask

   task automatic build_halt_program();
      plen = 0;
      emit(ldi_instr(5'd1, 22'd3));
      emit(ldi_instr(5'd2, 22'd7));
      emit(store_instr(5'd2, 5'd1));
      emit(halt_instr());
      emit(store_instr(5'd1, 5'd1));
      emit(store_instr(5'd2, 5'd2));
   endtask

   initial begin
      soft_rst   = 1'b1;
      run        = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      wb_dat_i   = '0;
      wb_ack     = 1'b0;
      check_reset_state();
      build_alu_program();
      run_test("ldi_alu");
      build_hazard_program();
      run_test("raw_hazard");
      build_memory_program();
      run_test("load_store");
      build_jump_program();
      run_test("jnz_loop");
      build_halt_program();
      run_test("halt");
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: flist.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_control.sv
cpu_pipelined.sv
tb_clock_gen.sv
cpu_assert.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu_pipelined

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - pipeline_control.sv
  - cpu_pipelined.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - cpu_assert.sv
      - tb_cpu.sv
